// File: hw/board_io_bus_pkg.sv
package board_io_bus_pkg;

   // Wishbone classic vector widths
   typedef logic [31:0] wb_addr_t;
   typedef logic [31:0] wb_data_t;
   typedef logic [3:0]  wb_sel_t;

   // Request as seen on the bus
   // Also the format of a host command
   typedef struct packed {
      // High for a write cycle
      logic     we;
      // Byte address
      wb_addr_t addr;
      // Byte lanes, only lane 3 matters to the LEDs
      wb_sel_t  sel;
      // Write payload
      wb_data_t wdata;
   } wb_req_t;

   // Response for one bus cycle
   typedef struct packed {
      // Unmapped address
      logic     err;
      // Zero on writes and errors
      wb_data_t rdata;
   } wb_rsp_t;

   // Command master FSM states
   typedef enum logic [1:0] {MST_IDLE, MST_BUS, MST_RESP} mst_state_e;

endpackage

// File: hw/board_io_map_pkg.sv
package board_io_map_pkg;

   // IO map, one-hot device selects inside a single window
   //   0110_0xxx ... xxxx_x1xx  LEDs
   //   0110_0xxx ... xxxx_1xxx  UART
   // Other select bits are free and decode as unmapped

   // Value of address bits 31:27 inside the IO window
   localparam logic [4:0] IO_BASE = 5'b01100;

   // Address bit that selects the LED register
   localparam int unsigned LED_SEL_BIT = 2;

   // Address bit that selects the bit-bang UART
   localparam int unsigned UART_SEL_BIT = 3;

   // Read data bit carrying the synchronized receive pin
   localparam int unsigned UART_RX_BIT = 8;

   // Write data bit, LED 2 follows the receive line when set
   localparam int unsigned LED_SRC_BIT = 31;

   // Byte lane that guards the LED 2 source flag
   localparam int unsigned LED_SRC_LANE = 3;

   // Four board LEDs
   // Bit 2 is the one shared with the UART
   typedef logic [3:0] led_vec_t;

endpackage

// File: hw/wb_cmd_master.sv
`timescale 1ns/1ps

module wb_cmd_master import board_io_bus_pkg::*; (
   input  logic    CLK_I,
   input  logic    rst_n,
   // Host command port
   input  logic    cmd_valid,
   input  wb_req_t cmd,
   output logic    cmd_ready,
   // Host response, one-cycle pulse
   output logic    rsp_valid,
   output wb_rsp_t rsp,
   // Wishbone classic master side
   output logic    cyc,
   output logic    stb,
   output wb_req_t req,
   input  logic    ack,
   input  wb_rsp_t bus_rsp
);

   mst_state_e state;
   mst_state_e state_nxt;
   logic       cmd_take;
   logic       rsp_valid_q;
   wb_req_t    req_q;
   wb_rsp_t    rsp_q;

   // Ready only when idle and the last response has gone out
   assign cmd_ready = (state == MST_IDLE) && !rsp_valid_q;
   assign cmd_take  = cmd_valid && cmd_ready;

   // Next state
   always_comb begin
      state_nxt = state;
      case (state)
         MST_IDLE: begin
            if (cmd_take) begin
               state_nxt = MST_BUS;
            end
         end
         // Hold the cycle until a slave or the decoder answers
         MST_BUS: begin
            if (ack) begin
               state_nxt = MST_RESP;
            end
         end
         MST_RESP: begin
            state_nxt = MST_IDLE;
         end
         default: begin
            state_nxt = MST_IDLE;
         end
      endcase
   end

   always_ff @(posedge CLK_I) begin
      if (!rst_n) begin
         state       <= MST_IDLE;
         rsp_valid_q <= 1'b0;
      end else begin
         state       <= state_nxt;
         // Pulse one cycle after the response is captured
         rsp_valid_q <= (state == MST_RESP);
      end
   end

   // Command and response payload
   always_ff @(posedge CLK_I) begin
      if (cmd_take) begin
         req_q <= cmd;
      end
      if ((state == MST_BUS) && ack) begin
         rsp_q <= bus_rsp;
      end
   end

   // Classic cycle, strobe and cycle move together
   assign cyc       = (state == MST_BUS);
   assign stb       = (state == MST_BUS);
   assign req       = req_q;
   assign rsp       = rsp_q;
   assign rsp_valid = rsp_valid_q;

endmodule

// File: hw/wb_io_decode.sv
`timescale 1ns/1ps

module wb_io_decode import board_io_bus_pkg::*, board_io_map_pkg::*; (
   // Master side
   input  wb_req_t req,
   input  logic    stb,
   // Slave acknowledges
   input  logic    led_ack,
   input  logic    uart_ack,
   // Synchronized receive level from the UART
   input  logic    rx_sync,
   // Slave strobes
   output logic    led_stb,
   output logic    uart_stb,
   // Merged answer back to the master
   output logic    ack,
   output wb_rsp_t bus_rsp
);

   logic in_window;
   logic led_hit;
   logic uart_hit;
   logic unmapped;

   // Top address bits must match the IO window
   assign in_window = (req.addr[$bits(wb_addr_t)-1 -: $bits(IO_BASE)] == IO_BASE);

   // One-hot selects, both may be set at once
   assign led_hit  = in_window && req.addr[LED_SEL_BIT];
   assign uart_hit = in_window && req.addr[UART_SEL_BIT];
   assign unmapped = !(led_hit || uart_hit);

   // Strobe fan-out
   assign led_stb  = stb && led_hit;
   assign uart_stb = stb && uart_hit;

   // Nobody home, answer at once so the bus cannot hang
   assign ack = led_ack || uart_ack || (stb && unmapped);

   // Read data assembly
   always_comb begin
      bus_rsp       = '0;
      bus_rsp.err   = stb && unmapped;
      // Only UART reads return data
      // LED register is write-only
      bus_rsp.rdata[UART_RX_BIT] = uart_ack && !req.we && rx_sync;
   end

endmodule

// File: hw/io_leds.sv
`timescale 1ns/1ps

module io_leds import board_io_bus_pkg::*, board_io_map_pkg::*; (
   input  logic     CLK_I,
   input  logic     rst_n,
   // Wishbone slave side
   input  logic     stb,
   input  wb_req_t  req,
   // Receive level, shown on LED 2 on request
   input  logic     rx_sync,
   output logic     ack,
   output led_vec_t leds
);

   logic     wr;
   logic     src_uart;
   led_vec_t led_q;

   // Zero wait states
   assign ack = stb;
   assign wr  = stb && req.we;

   always_ff @(posedge CLK_I) begin
      if (!rst_n) begin
         led_q    <= '0;
         src_uart <= 1'b0;
      end else begin
         if (wr) begin
            // LEDs 0, 1 and 3 always follow the register
            led_q[0] <= req.wdata[0];
            led_q[1] <= req.wdata[1];
            led_q[3] <= req.wdata[3];
            // Source flag only moves with its byte lane
            if (req.sel[LED_SRC_LANE]) begin
               src_uart <= req.wdata[LED_SRC_BIT];
            end
         end
         // LED 2 lit while the line is low
         if (src_uart) begin
            led_q[2] <= ~rx_sync;
         end else if (wr) begin
            led_q[2] <= req.wdata[2];
         end
      end
   end

   assign leds = led_q;

endmodule

// File: hw/io_bbuart.sv
`timescale 1ns/1ps

module io_bbuart import board_io_bus_pkg::*; (
   input  logic    CLK_I,
   input  logic    rst_n,
   // Wishbone slave side
   input  logic    stb,
   input  wb_req_t req,
   // Serial pins
   input  logic    uart_rx,
   output logic    ack,
   output logic    rx_sync,
   output logic    uart_tx
);

   logic rx_meta;
   logic rx_q;
   logic tx_q;

   // Zero wait states
   assign ack = stb;

   // Two-flop synchronizer for the asynchronous pin
   // Both stages come up at the idle level
   always_ff @(posedge CLK_I) begin
      if (!rst_n) begin
         rx_meta <= 1'b1;
         rx_q    <= 1'b1;
      end else begin
         rx_meta <= uart_rx;
         rx_q    <= rx_meta;
      end
   end

   // Transmit pin register, software does the framing
   always_ff @(posedge CLK_I) begin
      if (!rst_n) begin
         tx_q <= 1'b1;
      end else if (stb && req.we) begin
         tx_q <= req.wdata[0];
      end
   end

   assign rx_sync = rx_q;
   assign uart_tx = tx_q;

endmodule

// File: hw/board_io_top.sv
`timescale 1ns/1ps

module board_io_top import board_io_bus_pkg::*, board_io_map_pkg::*; (
   input  logic     CLK_I,
   input  logic     rst_n,
   // Host command port
   input  logic     cmd_valid,
   input  wb_req_t  cmd,
   output logic     cmd_ready,
   output logic     rsp_valid,
   output wb_rsp_t  rsp,
   // Board pins
   input  logic     uart_rx,
   output logic     uart_tx,
   output led_vec_t leds
);

   // Internal Wishbone bus
   logic    stb;
   wb_req_t bus_req;
   logic    ack;
   wb_rsp_t bus_rsp;
   // Per-device strobes and acknowledges
   logic    led_stb;
   logic    led_ack;
   logic    uart_stb;
   logic    uart_ack;
   // Receive level shared by decoder and LEDs
   logic    rx_sync;

   // Single master, stb alone qualifies a cycle downstream
   wb_cmd_master master_inst (
      .CLK_I     (CLK_I),
      .rst_n     (rst_n),
      .cmd_valid (cmd_valid),
      .cmd       (cmd),
      .cmd_ready (cmd_ready),
      .rsp_valid (rsp_valid),
      .rsp       (rsp),
      .cyc       (),
      .stb       (stb),
      .req       (bus_req),
      .ack       (ack),
      .bus_rsp   (bus_rsp)
   );

   wb_io_decode decode_inst (
      .req      (bus_req),
      .stb      (stb),
      .led_ack  (led_ack),
      .uart_ack (uart_ack),
      .rx_sync  (rx_sync),
      .led_stb  (led_stb),
      .uart_stb (uart_stb),
      .ack      (ack),
      .bus_rsp  (bus_rsp)
   );

   io_leds leds_inst (
      .CLK_I   (CLK_I),
      .rst_n   (rst_n),
      .stb     (led_stb),
      .req     (bus_req),
      .rx_sync (rx_sync),
      .ack     (led_ack),
      .leds    (leds)
   );

   io_bbuart uart_inst (
      .CLK_I   (CLK_I),
      .rst_n   (rst_n),
      .stb     (uart_stb),
      .req     (bus_req),
      .uart_rx (uart_rx),
      .ack     (uart_ack),
      .rx_sync (rx_sync),
      .uart_tx (uart_tx)
   );

endmodule

// File: dv/clk_rst_gen.sv
`timescale 1ns/1ps

module clk_rst_gen (
   output logic CLK_I,
   output logic rst_n
);

   // 8 ns period
   initial begin
      CLK_I = 1'b0;
      forever #4 CLK_I = ~CLK_I;
   end

   // Held over four rising edges, released on a falling edge
   initial begin
      rst_n = 1'b0;
      repeat (4) @(posedge CLK_I);
      @(negedge CLK_I);
      rst_n = 1'b1;
   end

endmodule

// File: dv/board_io_properties.sv
`timescale 1ns/1ps

module board_io_properties import board_io_bus_pkg::*; (
   input logic       CLK_I,
   input logic       rst_n,
   input logic       cyc,
   input logic       stb,
   input logic       cmd_ready,
   input logic       rsp_valid,
   input mst_state_e state
);

   // Failed assertions so far
   int unsigned fail_count = 0;

   // Classic bus, strobe only inside a cycle
   stb_in_cyc: assert property (@(posedge CLK_I) disable iff (!rst_n) stb |-> cyc)
      else begin
         $error("stb high without cyc");
         fail_count++;
      end

   // No new command while a bus cycle runs
   busy_not_ready: assert property (@(posedge CLK_I) disable iff (!rst_n) cyc |-> !cmd_ready)
      else begin
         $error("cmd_ready high during a bus cycle");
         fail_count++;
      end

   // Response is a single-cycle pulse
   rsp_pulse: assert property (@(posedge CLK_I) disable iff (!rst_n) rsp_valid |=> !rsp_valid)
      else begin
         $error("rsp_valid held for two cycles");
         fail_count++;
      end

   // Reset parks the FSM with the bus idle
   rst_idle: assert property (@(posedge CLK_I) !rst_n |=> (state == MST_IDLE) && !cyc)
      else begin
         $error("cyc raised or FSM busy during reset");
         fail_count++;
      end

endmodule

// File: dv/board_io_tb.sv
`timescale 1ns/1ps

module board_io_tb import board_io_bus_pkg::*, board_io_map_pkg::*; ();

   // One line of the vector file
   typedef struct packed {
      logic     rx;
      wb_req_t  cmd;
      wb_rsp_t  exp_rsp;
      led_vec_t exp_leds;
      logic     exp_tx;
   } vec_t;

   logic     CLK_I;
   logic     rst_n;
   logic     cmd_valid;
   wb_req_t  cmd;
   logic     cmd_ready;
   logic     rsp_valid;
   wb_rsp_t  rsp;
   logic     uart_rx;
   logic     uart_tx;
   led_vec_t leds;

   vec_t vecs[$];
   bit   loaded = 1'b0;
   int   accepted = 0;
   int   rsp_pulses = 0;
   // Error counts per kind of result
   int   err_rsp = 0;
   int   err_leds = 0;
   int   err_pin = 0;
   int   err_flow = 0;

   clk_rst_gen clk_rst_inst (.CLK_I(CLK_I), .rst_n(rst_n));

   board_io_top board_io_top_inst (
      .CLK_I     (CLK_I),
      .rst_n     (rst_n),
      .cmd_valid (cmd_valid),
      .cmd       (cmd),
      .cmd_ready (cmd_ready),
      .rsp_valid (rsp_valid),
      .rsp       (rsp),
      .uart_rx   (uart_rx),
      .uart_tx   (uart_tx),
      .leds      (leds)
   );

   bind wb_cmd_master board_io_properties props_inst (
      .CLK_I(CLK_I), .rst_n(rst_n), .cyc(cyc), .stb(stb),
      .cmd_ready(cmd_ready), .rsp_valid(rsp_valid), .state(state)
   );

   task automatic load_vectors();
      int               fd;
      int               n;
      int               line_no;
      logic [8*160-1:0] line_buf;
      vec_t             v;
      logic             f_rx;
      logic             f_we;
      wb_addr_t         f_addr;
      wb_sel_t          f_sel;
      wb_data_t         f_wdata;
      logic             f_err;
      wb_data_t         f_rdata;
      led_vec_t         f_leds;
      logic             f_tx;
      fd = $fopen("dv/board_io_input.txt", "r");
      if (fd == 0) begin
         err_flow++;
         $display("cannot open the vector file dv/board_io_input.txt");
         return;
      end
      line_no = 0;
      line_buf = '0;
      while ($fgets(line_buf, fd) != 0) begin
         line_no++;
         n = $sscanf(line_buf, "%h %h %h %h %h %h %h %h %h", f_rx, f_we, f_addr, f_sel,
                     f_wdata, f_err, f_rdata, f_leds, f_tx);
         // Comment lines give no fields
         if (n == 9) begin
            v.rx = f_rx;
            v.cmd = '{we: f_we, addr: f_addr, sel: f_sel, wdata: f_wdata};
            v.exp_rsp = '{err: f_err, rdata: f_rdata};
            v.exp_leds = f_leds;
            v.exp_tx = f_tx;
            vecs.push_back(v);
         end else if (n > 0) begin
            err_flow++;
            $display("vector file line %0d has %0d fields instead of 9", line_no, n);
         end
         line_buf = '0;
      end
      $fclose(fd);
      if (vecs.size() == 0) begin
         err_flow++;
         $display("vector file holds no vectors");
      end
   endtask

   task automatic check_rsp(input int idx, input wb_rsp_t got, input wb_rsp_t exp);
      if (got !== exp) begin
         err_rsp++;
         $display("CHECK FAILED vector %0d rsp: got 0x%h expected 0x%h", idx, got, exp);
      end
   endtask

   task automatic check_leds(input int idx, input led_vec_t got, input led_vec_t exp);
      if (got !== exp) begin
         err_leds++;
         $display("CHECK FAILED vector %0d leds: got 0x%h expected 0x%h", idx, got, exp);
      end
   endtask

   task automatic check_pin(input int idx, input string name, input logic got, input logic exp);
      if (got !== exp) begin
         err_pin++;
         $display("CHECK FAILED vector %0d %s: got 0x%h expected 0x%h", idx, name, got, exp);
      end
   endtask

   // Starts and ends on a falling edge
   task automatic run_vector(input int idx);
      vec_t v;
      int   gap;
      int   k;
      v = vecs[idx];
      // New rx level needs two sync edges plus one LED edge
      if (uart_rx !== v.rx) begin
         uart_rx = v.rx;
         repeat (3) @(negedge CLK_I);
      end
      gap = int'($urandom_range(5));
      repeat (gap) @(negedge CLK_I);
      cmd = v.cmd;
      cmd_valid = 1'b1;
      while (!cmd_ready) @(negedge CLK_I);
      // Accepted on this rising edge
      @(posedge CLK_I);
      accepted++;
      @(negedge CLK_I);
      cmd_valid = 1'b0;
      cmd = '0;
      for (k = 0; k < 3 && !rsp_valid; k++) begin
         if (cmd_ready) begin
            err_flow++;
            $display("vector %0d: cmd_ready high while the command is in flight", idx);
         end
         @(negedge CLK_I);
      end
      if (!rsp_valid) begin
         err_flow++;
         $display("vector %0d: no response 3 cycles after the command was accepted", idx);
         return;
      end
      if (k != 2) begin
         err_flow++;
         $display("vector %0d: response came %0d cycles after acceptance, not 2", idx, k);
      end
      if (cmd_ready) begin
         err_flow++;
         $display("vector %0d: cmd_ready high together with the response", idx);
      end
      check_rsp(idx, rsp, v.exp_rsp);
      @(negedge CLK_I);
      if (!cmd_ready) begin
         err_flow++;
         $display("vector %0d: cmd_ready still low one cycle after the response", idx);
      end
      check_leds(idx, leds, v.exp_leds);
      check_pin(idx, "uart_tx", uart_tx, v.exp_tx);
   endtask

   // Each pulse is seen on exactly one falling edge
   always @(negedge CLK_I) begin
      if (rst_n && rsp_valid) begin
         rsp_pulses++;
      end
   end

   initial begin
      int total;
      int asrt;
      cmd_valid = 1'b0;
      cmd = '0;
      uart_rx = 1'b1;
      void'($urandom(32'h4329));
      load_vectors();
      loaded = 1'b1;
      wait (rst_n === 1'b1);
      @(negedge CLK_I);
      for (int i = 0; i < vecs.size(); i++) begin
         run_vector(i);
      end
      repeat (2) @(negedge CLK_I);
      if (rsp_pulses != accepted) begin
         err_flow++;
         $display("%0d response pulses for %0d accepted commands", rsp_pulses, accepted);
      end
      asrt = int'(board_io_top_inst.master_inst.props_inst.fail_count);
      $display("errors: rsp %0d, leds %0d, pins %0d, handshake %0d, assertions %0d",
               err_rsp, err_leds, err_pin, err_flow, asrt);
      total = err_rsp + err_leds + err_pin + err_flow + asrt;
      if (total == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

   // 20 cycles per vector plus reset
   initial begin
      wait (loaded);
      repeat (5 + 20 * vecs.size()) @(posedge CLK_I);
      $display("watchdog expired after %0d cycles", 5 + 20 * vecs.size());
      $display("tests failed");
      $finish;
   end

endmodule

// File: dv/board_io_input.txt
# uart_rx we addr sel wdata  then expected: err rdata leds uart_tx
# all fields hex, one transaction per line, text after the fields is ignored
1 0 60000008 f 00000000 0 00000100 0 1  # idle rx, tx at reset level
1 1 60000004 f 00000005 0 00000000 5 1
1 1 60000004 f 0000000a 0 00000000 a 1
1 1 60000004 f 0000000f 0 00000000 f 1
1 1 60000004 f 00000000 0 00000000 0 1
1 1 60000004 1 00000004 0 00000000 4 1  # lane 3 off, LED bits still written
1 0 60000004 f 00000000 0 00000000 4 1  # LED read returns zero
0 0 60000008 f 00000000 0 00000000 4 1
1 0 60000008 f 00000000 0 00000100 4 1
1 1 60000008 f 00000000 0 00000000 4 0
1 1 60000008 f 00000001 0 00000000 4 1
1 1 60000008 f fffffffe 0 00000000 4 0
1 1 60000008 1 00000001 0 00000000 4 1
1 1 60000004 8 80000003 0 00000000 3 1  # LED 2 now follows rx, line high
0 0 60000008 f 00000000 0 00000000 7 1
0 1 60000004 1 00000009 0 00000000 d 1  # data bit 2 ignored
1 0 60000008 f 00000000 0 00000100 9 1
0 1 60000004 7 00000002 0 00000000 6 1
0 1 60000004 8 00000004 0 00000000 4 1  # LED 2 back to the register
1 0 60000008 f 00000000 0 00000100 4 1  # LED 2 holds
1 1 60000004 8 00000001 0 00000000 1 1
0 1 60000004 7 80000000 0 00000000 0 1  # bit 31 without lane 3
0 0 60000008 f 00000000 0 00000000 0 1
0 1 60000000 f 0000000f 1 00000000 0 1  # window, no select
0 1 68000004 f 0000000f 1 00000000 0 1
0 1 00000004 f 0000000f 1 00000000 0 1
1 0 e0000008 f 00000000 1 00000000 0 1
1 1 60000010 f 00000000 1 00000000 0 1
1 1 70000008 f 00000000 1 00000000 0 1
1 1 6000000c f 00000002 0 00000000 2 0  # both devices
1 0 6000000c f 00000000 0 00000100 2 0  # read data from the UART
0 0 6000000c f 00000000 0 00000000 2 0
1 1 60000008 f 00000001 0 00000000 2 1
1 1 60000004 f 0000000b 0 00000000 b 1
1 1 60000004 f 7ffffff4 0 00000000 4 1
1 1 60000007 f 00000003 0 00000000 3 1  # byte offset ignored
1 1 67fffff4 f 00000006 0 00000000 6 1

// File: board_io.f
hw/board_io_bus_pkg.sv
hw/board_io_map_pkg.sv
hw/wb_cmd_master.sv
hw/wb_io_decode.sv
hw/io_leds.sv
hw/io_bbuart.sv
hw/board_io_top.sv
dv/clk_rst_gen.sv
dv/board_io_properties.sv
dv/board_io_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the board_io testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
   --top-module board_io_tb -f board_io.f -o board_io_sim

# Assertion errors are counted by the testbench, so let the run continue
./obj_dir/board_io_sim +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -qx "all tests passed" sim.log; then
   echo "PASS"
else
   echo "FAIL"
   exit 1
fi
